//--- forwardUnit.f
hdl/fwdPkg.sv
hdl/regFieldsIf.sv
hdl/hazardIf.sv
hdl/regFieldDecode.sv
hdl/hazardCompare.sv
hdl/forwardSelect.sv
hdl/forwardUnit.sv
tb/forwardUnit_assert.sv
tb/forwardUnit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the forwardUnit testbench with Verilator.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module forwardUnit_tb \
    --Mdir obj_dir -o forwardUnit_sim \
    -f forwardUnit.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/forwardUnit_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

//--- tb/forwardUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;

    logic            clk;
    logic            rst;
    fwdPkg::inst_t   inst;
    logic            instValid;
    logic            fwdValid;
    fwdPkg::fwdSel_t fwdRs;
    fwdPkg::fwdSel_t fwdRt;

    // One entry per instruction in each of the four queues
    string           rowName[$];
    fwdPkg::inst_t   rowInst[$];
    fwdPkg::fwdSel_t rowRs[$];
    fwdPkg::fwdSel_t rowRt[$];
    bit              tableReady = 1'b0;

    int seed = 32'h21f8_dabb;
    int gap;

    forwardUnit UUT (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .instValid (instValid),
        .fwdValid  (fwdValid),
        .fwdRs     (fwdRs),
        .fwdRt     (fwdRt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Table helpers
    //////////////////////////////////////////////////

    // Opcode, Rs, Rt, Rd and two spare bits
    function automatic fwdPkg::inst_t encode(
        input logic [4:0]       op,
        input fwdPkg::regAddr_t rs,
        input fwdPkg::regAddr_t rt,
        input fwdPkg::regAddr_t rd
    );
        return {op, rs, rt, rd, 2'b00};
    endfunction

    task automatic addRow(
        input string           name,
        input fwdPkg::inst_t   word,
        input fwdPkg::fwdSel_t expRs,
        input fwdPkg::fwdSel_t expRt
    );
        rowName.push_back(name);
        rowInst.push_back(word);
        rowRs.push_back(expRs);
        rowRt.push_back(expRt);
    endtask

    // History after each row noted as EX/MEM
    // A dash marks an empty slot
    task automatic buildTable();
        addRow("resetFirstAdd", encode(fwdPkg::OP_ALU_R, 1, 2, 3),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // r3/-
        addRow("exBothOperands", encode(fwdPkg::OP_ALU_R, 3, 3, 4),
               fwdPkg::FWD_EX, fwdPkg::FWD_EX);
        addRow("unrelatedAddi", encode(fwdPkg::OP_ADDI, 0, 5, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        addRow("memRs", encode(fwdPkg::OP_ALU_R, 4, 1, 6),
               fwdPkg::FWD_MEM, fwdPkg::FWD_NONE);
        // r6/r5
        addRow("addiWritesR2", encode(fwdPkg::OP_ADDI, 0, 2, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        addRow("addiWritesR2Again", encode(fwdPkg::OP_ADDI, 1, 2, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // r2/r2
        // Youngest writer wins
        addRow("exBeatsMem", encode(fwdPkg::OP_ALU_R, 2, 0, 1),
               fwdPkg::FWD_EX, fwdPkg::FWD_NONE);
        // r1/r2
        addRow("storeReads", encode(fwdPkg::OP_ST, 1, 2, 0),
               fwdPkg::FWD_EX, fwdPkg::FWD_MEM);
        // -/r1
        // Store Rt field r2 is not a writer
        addRow("jrAfterStore", encode(fwdPkg::OP_JR, 2, 0, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        addRow("branchNoWriters", encode(fwdPkg::OP_BEQZ, 1, 0, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // -/-
        // Reads the registers named by the branch and the JR
        addRow("readAfterBranch", encode(fwdPkg::OP_ALU_R, 1, 2, 6),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // r6/-
        addRow("lbiNoSources", encode(fwdPkg::OP_LBI, 6, 2, 6),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // r6/r6
        // Displacement bits look like r6
        addRow("jalWritesLink", encode(fwdPkg::OP_JAL, 6, 6, 6),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // r7/r6
        addRow("jrLinkEx", encode(fwdPkg::OP_JR, 7, 0, 0),
               fwdPkg::FWD_EX, fwdPkg::FWD_NONE);
        // -/r7
        addRow("jalrLinkMem", encode(fwdPkg::OP_JALR, 7, 0, 0),
               fwdPkg::FWD_MEM, fwdPkg::FWD_NONE);
        // r7/-
        // Rt field of an ADDI is a destination
        addRow("addiRtUnused", encode(fwdPkg::OP_ADDI, 0, 7, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        addRow("lbiRsUnused", encode(fwdPkg::OP_LBI, 7, 0, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        addRow("slbiReadsRs", encode(fwdPkg::OP_SLBI, 7, 0, 0),
               fwdPkg::FWD_EX, fwdPkg::FWD_NONE);
        // r7/r7
        addRow("stuReadsRt", encode(fwdPkg::OP_STU, 2, 7, 0),
               fwdPkg::FWD_NONE, fwdPkg::FWD_EX);
        // r2/r7
        addRow("ldRtUnused", encode(fwdPkg::OP_LD, 2, 7, 0),
               fwdPkg::FWD_EX, fwdPkg::FWD_NONE);
        // r7/r2
        addRow("sltExMem", encode(fwdPkg::OP_SLT, 7, 2, 0),
               fwdPkg::FWD_EX, fwdPkg::FWD_MEM);
        // r0/r7
        addRow("nopNoUse", encode(5'b00000, 7, 7, 3),
               fwdPkg::FWD_NONE, fwdPkg::FWD_NONE);
        // -/r0
        addRow("memAfterNop", encode(fwdPkg::OP_ALU_R, 0, 3, 1),
               fwdPkg::FWD_MEM, fwdPkg::FWD_NONE);
    endtask

    task automatic driveRow(input int idx);
        inst      <= rowInst[idx];
        instValid <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic compareSel(
        input string           name,
        input string           operand,
        input fwdPkg::fwdSel_t expected,
        input fwdPkg::fwdSel_t actual
    );
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %s, actual %s (%0d)",
                     name, operand, expected.name(), actual.name(), actual);
            $display("RESULT: FAIL");
            $fatal(1, "Forwarding select mismatch");
        end
    endtask

    task automatic expectStrobe(input string name, input logic actual);
        if (actual !== 1'b1) begin
            $display("fwdValid did not rise one cycle after the strobe of %s", name);
            $display("RESULT: FAIL");
            $fatal(1, "Missing result strobe");
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////

    initial begin
        int idx;
        int last;

        clk       = 1'b0;
        rst       = 1'b1;
        inst      = '0;
        instValid = 1'b0;
        buildTable();
        last       = rowName.size() - 1;
        tableReady = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        driveRow(0);

        for (idx = 0; idx <= last; idx++) begin
            // Row idx is captured at this edge
            @(posedge clk);
            gap = (idx == last) ? 1 : $unsigned($random(seed)) % 3;
            if (gap == 0) begin
                driveRow(idx + 1);
            end else begin
                instValid <= 1'b0;
            end

            @(negedge clk);
            expectStrobe(rowName[idx], fwdValid);
            compareSel(rowName[idx], "fwdRs", rowRs[idx], fwdRs);
            compareSel(rowName[idx], "fwdRt", rowRt[idx], fwdRt);

            // Idle cycles before the next strobe
            if (gap != 0 && idx < last) begin
                repeat (gap) @(posedge clk);
                driveRow(idx + 1);
            end
        end

        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    // At most three cycles per row plus reset and margin
    initial begin
        wait (tableReady);
        #((rowName.size() * 4 + 20) * CLK_PERIOD);
        $display("Watchdog expired before all rows were checked");
        $display("RESULT: FAIL");
        $fatal(1, "Simulation timeout");
    end

endmodule

`default_nettype wire

//--- tb/forwardUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit_assert (
    input logic clk,
    input logic rst,
    input logic instValid,
    input logic fwdValid
);

    // Set by the first strobe after reset
    logic strobeSeen;

    always_ff @(posedge clk) begin
        if (rst) begin
            strobeSeen <= 1'b0;
        end else if (instValid) begin
            strobeSeen <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Result strobe timing
    //////////////////////////////////////////////////

    // Two results in a row need two strobes in a row
    backToBack: assert property (@(posedge clk) disable iff (rst)
        fwdValid && $past(fwdValid) |-> $past(instValid) && $past(instValid, 2))
        else $error("fwdValid high twice without two consecutive strobes");

    strobeGivesResult: assert property (@(posedge clk) disable iff (rst)
        instValid |=> fwdValid)
        else $error("fwdValid missing one cycle after instValid");

    noStrobeNoResult: assert property (@(posedge clk) disable iff (rst)
        !instValid |=> !fwdValid)
        else $error("fwdValid high without a strobe one cycle before");

    // Quiet until the first instruction arrives
    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        !strobeSeen |-> !fwdValid)
        else $error("fwdValid high after reset before any strobe");

endmodule

bind forwardUnit forwardUnit_assert portChecks (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .fwdValid  (fwdValid)
);

`default_nettype wire

//--- hdl/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  logic            clk,
    input  logic            rst,
    input  fwdPkg::inst_t   inst,
    input  logic            instValid,
    output logic            fwdValid,
    output fwdPkg::fwdSel_t fwdRs,
    output fwdPkg::fwdSel_t fwdRt
);

    //////////////////////////////////////////////////
    // Internal buses
    //////////////////////////////////////////////////

    regFieldsIf fieldsBus ();
    hazardIf    matchBus ();

    //////////////////////////////////////////////////
    // Decode, compare, select
    //////////////////////////////////////////////////

    // Source and destination fields of the incoming instruction
    regFieldDecode decode (
        .inst   (inst),
        .fields (fieldsBus.decoder)
    );

    // Compare against the two previous writers
    hazardCompare compare (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .fields    (fieldsBus.consumer),
        .match     (matchBus.producer)
    );

    // One cycle to the registered selects
    forwardSelect select (
        .clk      (clk),
        .rst      (rst),
        .match    (matchBus.consumer),
        .fwdValid (fwdValid),
        .fwdRs    (fwdRs),
        .fwdRt    (fwdRt)
    );

endmodule

`default_nettype wire

//--- hdl/forwardSelect.sv
`timescale 1ns/1ps
`default_nettype none

module forwardSelect (
    input  logic            clk,
    input  logic            rst,
    hazardIf.consumer       match,
    output logic            fwdValid,
    output fwdPkg::fwdSel_t fwdRs,
    output fwdPkg::fwdSel_t fwdRt
);

    // Youngest writer wins
    function automatic fwdPkg::fwdSel_t pickSource(
        input logic exHit,
        input logic memHit
    );
        if (exHit) begin
            return fwdPkg::FWD_EX;
        end else if (memHit) begin
            return fwdPkg::FWD_MEM;
        end
        return fwdPkg::FWD_NONE;
    endfunction

    //////////////////////////////////////////////////
    // Registered selects
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdValid <= 1'b0;
            fwdRs    <= fwdPkg::FWD_NONE;
            fwdRt    <= fwdPkg::FWD_NONE;
        end else begin
            fwdValid <= match.valid;
            // Selects hold until the next instruction
            if (match.valid) begin
                fwdRs <= pickSource(match.rsMatchEx, match.rsMatchMem);
                fwdRt <= pickSource(match.rtMatchEx, match.rtMatchMem);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazardCompare.sv
`timescale 1ns/1ps
`default_nettype none

module hazardCompare (
    input  logic         clk,
    input  logic         rst,
    input  logic         instValid,
    regFieldsIf.consumer fields,
    hazardIf.producer    match
);

    // One source against one history slot
    function automatic logic slotHit(
        input logic             srcUsed,
        input fwdPkg::regAddr_t src,
        input logic             slotValid,
        input fwdPkg::regAddr_t slotDest
    );
        return srcUsed && slotValid && (src == slotDest);
    endfunction

    //////////////////////////////////////////////////
    // Writer history
    //////////////////////////////////////////////////

    // EX slot is the previous instruction, MEM slot the one before
    logic             exValid;
    logic             memValid;
    fwdPkg::regAddr_t exDest;
    fwdPkg::regAddr_t memDest;

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid  <= 1'b0;
            memValid <= 1'b0;
        end else if (instValid) begin
            exValid  <= fields.destValid;
            memValid <= exValid;
        end
    end

    // Only advances on a strobe so idle cycles keep the history
    always_ff @(posedge clk) begin
        if (instValid) begin
            exDest  <= fields.dest;
            memDest <= exDest;
        end
    end

    //////////////////////////////////////////////////
    // Match flags
    //////////////////////////////////////////////////

    assign match.valid = instValid;

    assign match.rsMatchEx  = slotHit(fields.rsUsed, fields.rs, exValid, exDest);
    assign match.rsMatchMem = slotHit(fields.rsUsed, fields.rs, memValid, memDest);
    assign match.rtMatchEx  = slotHit(fields.rtUsed, fields.rt, exValid, exDest);
    assign match.rtMatchMem = slotHit(fields.rtUsed, fields.rt, memValid, memDest);

endmodule

`default_nettype wire

//--- hdl/regFieldDecode.sv
`timescale 1ns/1ps
`default_nettype none

module regFieldDecode (
    input  fwdPkg::inst_t inst,
    regFieldsIf.decoder   fields
);

    //////////////////////////////////////////////////
    // Raw instruction fields
    //////////////////////////////////////////////////

    fwdPkg::opcode_t  opcode;
    fwdPkg::regAddr_t rsField;
    fwdPkg::regAddr_t rtField;
    fwdPkg::regAddr_t rdField;

    assign opcode  = fwdPkg::opcode_t'(inst[15:11]);
    assign rsField = inst[10:8];
    assign rtField = inst[7:5];
    assign rdField = inst[4:2];

    logic             rsUsed;
    logic             rtUsed;
    logic             destValid;
    fwdPkg::regAddr_t dest;

    //////////////////////////////////////////////////
    // Register use per opcode
    //////////////////////////////////////////////////

    always_comb begin
        rsUsed    = 1'b0;
        rtUsed    = 1'b0;
        destValid = 1'b0;
        dest      = '0;

        case (opcode)
            // R-format arithmetic, shifts, sets and BTR
            fwdPkg::OP_BTR, fwdPkg::OP_ALU_R, fwdPkg::OP_SHIFT_R,
            fwdPkg::OP_SEQ, fwdPkg::OP_SLT, fwdPkg::OP_SLE, fwdPkg::OP_SCO: begin
                rsUsed    = 1'b1;
                rtUsed    = 1'b1;
                destValid = 1'b1;
                dest      = rdField;
            end
            // Immediate arithmetic and shifts, Rt field is the destination
            fwdPkg::OP_ADDI, fwdPkg::OP_SUBI, fwdPkg::OP_XORI, fwdPkg::OP_ANDNI,
            fwdPkg::OP_ROLI, fwdPkg::OP_SLLI, fwdPkg::OP_RORI, fwdPkg::OP_SRLI,
            fwdPkg::OP_LD: begin
                rsUsed    = 1'b1;
                destValid = 1'b1;
                dest      = rtField;
            end
            fwdPkg::OP_ST: begin
                rsUsed = 1'b1;
                rtUsed = 1'b1;
            end
            // Store with base update
            fwdPkg::OP_STU: begin
                rsUsed    = 1'b1;
                rtUsed    = 1'b1;
                destValid = 1'b1;
                dest      = rsField;
            end
            // Shift and load reads and writes the same register
            fwdPkg::OP_SLBI: begin
                rsUsed    = 1'b1;
                destValid = 1'b1;
                dest      = rsField;
            end
            fwdPkg::OP_LBI: begin
                destValid = 1'b1;
                dest      = rsField;
            end
            fwdPkg::OP_JR: begin
                rsUsed = 1'b1;
            end
            fwdPkg::OP_JALR: begin
                rsUsed    = 1'b1;
                destValid = 1'b1;
                dest      = fwdPkg::LINK_REG;
            end
            fwdPkg::OP_JAL: begin
                destValid = 1'b1;
                dest      = fwdPkg::LINK_REG;
            end
            fwdPkg::OP_BEQZ, fwdPkg::OP_BNEZ, fwdPkg::OP_BLTZ, fwdPkg::OP_BGEZ: begin
                rsUsed = 1'b1;
            end
            // J-format, halt, nop and the rest touch no registers
            default: begin
                rsUsed = 1'b0;
            end
        endcase
    end

    assign fields.rs        = rsField;
    assign fields.rt        = rtField;
    assign fields.rsUsed    = rsUsed;
    assign fields.rtUsed    = rtUsed;
    assign fields.dest      = dest;
    assign fields.destValid = destValid;

endmodule

`default_nettype wire

//--- hdl/hazardIf.sv
`timescale 1ns/1ps
`default_nettype none

// Per-operand stage matches for the current instruction
interface hazardIf;

    logic valid;

    logic rsMatchEx;
    logic rsMatchMem;
    logic rtMatchEx;
    logic rtMatchMem;

    modport producer (
        output valid,
        output rsMatchEx,
        output rsMatchMem,
        output rtMatchEx,
        output rtMatchMem
    );

    modport consumer (
        input valid,
        input rsMatchEx,
        input rsMatchMem,
        input rtMatchEx,
        input rtMatchMem
    );

endinterface

`default_nettype wire

//--- hdl/regFieldsIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded register use of one instruction
interface regFieldsIf;

    fwdPkg::regAddr_t rs;
    fwdPkg::regAddr_t rt;
    logic             rsUsed;
    logic             rtUsed;

    fwdPkg::regAddr_t dest;
    logic             destValid;

    modport decoder (
        output rs,
        output rt,
        output rsUsed,
        output rtUsed,
        output dest,
        output destValid
    );

    modport consumer (
        input rs,
        input rt,
        input rsUsed,
        input rtUsed,
        input dest,
        input destValid
    );

endinterface

`default_nettype wire

//--- hdl/fwdPkg.sv
`default_nettype none

package fwdPkg;

    //////////////////////////////////////////////////
    // Instruction and register types
    //////////////////////////////////////////////////

    // Opcode 15:11, Rs 10:8, Rt or I-format dest 7:5, R-format dest 4:2
    typedef logic [15:0] inst_t;

    typedef logic [2:0] regAddr_t;

    // Written by JAL and JALR
    localparam regAddr_t LINK_REG = 3'd7;

    //////////////////////////////////////////////////
    // Opcodes with register use
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_JR      = 5'b00101,
        OP_JAL     = 5'b00110,
        OP_JALR    = 5'b00111,
        OP_ADDI    = 5'b01000,
        OP_SUBI    = 5'b01001,
        OP_XORI    = 5'b01010,
        OP_ANDNI   = 5'b01011,
        OP_BEQZ    = 5'b01100,
        OP_BNEZ    = 5'b01101,
        OP_BLTZ    = 5'b01110,
        OP_BGEZ    = 5'b01111,
        OP_ST      = 5'b10000,
        OP_LD      = 5'b10001,
        OP_SLBI    = 5'b10010,
        OP_STU     = 5'b10011,
        OP_ROLI    = 5'b10100,
        OP_SLLI    = 5'b10101,
        OP_RORI    = 5'b10110,
        OP_SRLI    = 5'b10111,
        OP_LBI     = 5'b11000,
        OP_BTR     = 5'b11001,
        OP_SHIFT_R = 5'b11010,
        OP_ALU_R   = 5'b11011,
        OP_SEQ     = 5'b11100,
        OP_SLT     = 5'b11101,
        OP_SLE     = 5'b11110,
        OP_SCO     = 5'b11111
    } opcode_t;

    // Operand source chosen for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2
    } fwdSel_t;

endpackage

`default_nettype wire
